// File: logic/pcs_rx_pkg.sv
`default_nettype none

package pcs_rx_pkg;

        // ******************************************************************
        // block geometry
        // ******************************************************************

        // one 64b/66b coded block.
        localparam int NB_BLOCK = 66;
        localparam int NB_SH = 2;

        // lane 0 sits in the least significant block of the bus.
        localparam int N_LANES = 4;
        localparam int NB_DATA_BUS = N_LANES * NB_BLOCK;

        // slip index counts 0 to NB_BLOCK-1.
        localparam int NB_INDEX = $clog2(NB_BLOCK);

        // ******************************************************************
        // lock timers
        // ******************************************************************

        localparam int MAX_WINDOW = 4096;
        localparam int NB_WINDOW_CNT = $clog2(MAX_WINDOW);

        // at most half a window of bad headers.
        localparam int NB_INVALID_CNT = $clog2(MAX_WINDOW / 2);

        // ******************************************************************
        // sync header codes
        // ******************************************************************

        // header is in the two msbs of a block.
        localparam logic [NB_SH-1:0] SH_DATA = 2'b01;
        localparam logic [NB_SH-1:0] SH_CTRL = 2'b10;

endpackage

`default_nettype wire

// File: logic/block_aligner.sv
`timescale 1ns/100ps
`default_nettype none

module block_aligner
        import pcs_rx_pkg::*;
(
        input  logic                    i_clock,
        input  logic                    i_arst_n,
        input  logic                    i_valid,
        input  logic [NB_BLOCK-1:0]     i_data,
        input  logic                    i_slip,
        output logic                    o_valid,
        output logic [NB_BLOCK-1:0]     o_data
);

        localparam logic [NB_INDEX-1:0] LAST_INDEX = NB_INDEX'(NB_BLOCK - 1);

        logic [NB_BLOCK-1:0]    prev_word;
        logic [NB_INDEX-1:0]    index;
        logic [2*NB_BLOCK-1:0]  window;

        // previous valid word, kept for the next block.
        always_ff @(posedge i_clock or negedge i_arst_n) begin
                if (!i_arst_n) begin
                        prev_word <= '0;
                end
                else if (i_valid) begin
                        prev_word <= i_data;
                end
        end

        // slip moves the window one bit later in the stream.
        always_ff @(posedge i_clock or negedge i_arst_n) begin
                if (!i_arst_n) begin
                        index <= '0;
                end
                else if (i_slip) begin
                        if (index == LAST_INDEX) begin
                                index <= '0;
                        end
                        else begin
                                index <= index + 1'b1;
                        end
                end
        end

        // older word in the upper half, msb first on the line.
        assign window = {prev_word, i_data};

        // index 0 gives back the previous word unchanged.
        assign o_data = window[2*NB_BLOCK-1-index -: NB_BLOCK];
        assign o_valid = i_valid;

endmodule

`default_nettype wire

// File: logic/block_lock_fsm.sv
`timescale 1ns/100ps
`default_nettype none

module block_lock_fsm
        import pcs_rx_pkg::*;
(
        input  logic                            i_clock,
        input  logic                            i_arst_n,
        input  logic                            i_valid,
        input  logic                            i_enable,
        input  logic                            i_signal_ok,
        input  logic [NB_SH-1:0]                i_sh,
        input  logic [NB_WINDOW_CNT-1:0]        i_unlocked_timer_limit,
        input  logic [NB_WINDOW_CNT-1:0]        i_locked_timer_limit,
        input  logic [NB_INVALID_CNT-1:0]       i_sh_invalid_limit,
        output logic                            o_slip,
        output logic                            o_sh_valid,
        output logic                            o_block_lock
);

        typedef enum logic {
                ST_UNLOCKED,
                ST_LOCKED
        } state_t;

        state_t                         state;
        logic [NB_WINDOW_CNT-1:0]       good_cnt;
        logic [NB_WINDOW_CNT-1:0]       win_cnt;
        logic [NB_INVALID_CNT-1:0]      inv_cnt;

        // one extra bit so a limit of all ones is still reachable.
        logic [NB_WINDOW_CNT:0]         good_cnt_next;
        logic [NB_WINDOW_CNT:0]         win_cnt_next;
        logic [NB_INVALID_CNT:0]        inv_cnt_next;
        logic                           sh_ok;
        logic                           strobe;
        logic                           good_done;
        logic                           win_done;
        logic                           inv_done;

        assign sh_ok = (i_sh == SH_DATA) || (i_sh == SH_CTRL);
        assign strobe = i_valid && i_enable;

        assign good_cnt_next = {1'b0, good_cnt} + 1'b1;
        assign win_cnt_next = {1'b0, win_cnt} + 1'b1;
        assign inv_cnt_next = {1'b0, inv_cnt} + 1'b1;

        assign good_done = good_cnt_next >= {1'b0, i_unlocked_timer_limit};
        assign win_done = win_cnt_next >= {1'b0, i_locked_timer_limit};
        assign inv_done = inv_cnt_next >= {1'b0, i_sh_invalid_limit};

        // ******************************************************************
        // lock state and counters
        // ******************************************************************

        always_ff @(posedge i_clock or negedge i_arst_n) begin
                if (!i_arst_n) begin
                        state <= ST_UNLOCKED;
                        good_cnt <= '0;
                        win_cnt <= '0;
                        inv_cnt <= '0;
                end
                else if (!i_signal_ok) begin
                        state <= ST_UNLOCKED;
                        good_cnt <= '0;
                        win_cnt <= '0;
                        inv_cnt <= '0;
                end
                else if (strobe) begin
                        case (state)
                                ST_UNLOCKED: begin
                                        // any bad header restarts the run.
                                        if (!sh_ok) begin
                                                good_cnt <= '0;
                                        end
                                        else if (good_done) begin
                                                state <= ST_LOCKED;
                                                good_cnt <= '0;
                                                win_cnt <= '0;
                                                inv_cnt <= '0;
                                        end
                                        else begin
                                                good_cnt <= good_cnt_next[NB_WINDOW_CNT-1:0];
                                        end
                                end
                                ST_LOCKED: begin
                                        if (!sh_ok && inv_done) begin
                                                state <= ST_UNLOCKED;
                                                win_cnt <= '0;
                                                inv_cnt <= '0;
                                        end
                                        else if (win_done) begin
                                                // window over, errors forgiven.
                                                win_cnt <= '0;
                                                inv_cnt <= '0;
                                        end
                                        else begin
                                                win_cnt <= win_cnt_next[NB_WINDOW_CNT-1:0];
                                                if (!sh_ok) begin
                                                        inv_cnt <= inv_cnt_next[NB_INVALID_CNT-1:0];
                                                end
                                        end
                                end
                                default: begin
                                        state <= ST_UNLOCKED;
                                end
                        endcase
                end
        end

        // slip lands on the aligner index at this same edge.
        assign o_slip = i_signal_ok && strobe && (state == ST_UNLOCKED) && !sh_ok;
        assign o_sh_valid = sh_ok;
        assign o_block_lock = (state == ST_LOCKED);

endmodule

`default_nettype wire

// File: logic/block_sync_lane.sv
`timescale 1ns/100ps
`default_nettype none

module block_sync_lane
        import pcs_rx_pkg::*;
(
        input  logic                            i_clock,
        input  logic                            i_arst_n,
        input  logic                            i_valid,
        input  logic                            i_enable,
        input  logic                            i_signal_ok,
        input  logic [NB_BLOCK-1:0]             i_data,
        input  logic [NB_WINDOW_CNT-1:0]        i_unlocked_timer_limit,
        input  logic [NB_WINDOW_CNT-1:0]        i_locked_timer_limit,
        input  logic [NB_INVALID_CNT-1:0]       i_sh_invalid_limit,
        output logic [NB_BLOCK-1:0]             o_data,
        output logic                            o_valid,
        output logic                            o_sh_valid,
        output logic                            o_block_lock
);

        logic                   aligned_valid;
        logic [NB_BLOCK-1:0]    aligned_data;
        logic                   slip;
        logic                   sh_valid;

        block_aligner u_aligner (
                .i_clock        (i_clock),
                .i_arst_n       (i_arst_n),
                .i_valid        (i_valid),
                .i_data         (i_data),
                .i_slip         (slip),
                .o_valid        (aligned_valid),
                .o_data         (aligned_data)
        );

        block_lock_fsm u_lock_fsm (
                .i_clock                (i_clock),
                .i_arst_n               (i_arst_n),
                .i_valid                (aligned_valid),
                .i_enable               (i_enable),
                .i_signal_ok            (i_signal_ok),
                .i_sh                   (aligned_data[NB_BLOCK-1 -: NB_SH]),
                .i_unlocked_timer_limit (i_unlocked_timer_limit),
                .i_locked_timer_limit   (i_locked_timer_limit),
                .i_sh_invalid_limit     (i_sh_invalid_limit),
                .o_slip                 (slip),
                .o_sh_valid             (sh_valid),
                .o_block_lock           (o_block_lock)
        );

        // block holds across gaps, flags only on valid words.
        always_ff @(posedge i_clock or negedge i_arst_n) begin
                if (!i_arst_n) begin
                        o_data <= '0;
                        o_valid <= 1'b0;
                        o_sh_valid <= 1'b0;
                end
                else begin
                        if (aligned_valid) begin
                                o_data <= aligned_data;
                        end
                        o_valid <= aligned_valid;
                        o_sh_valid <= aligned_valid && sh_valid;
                end
        end

endmodule

`default_nettype wire

// File: logic/block_sync_top.sv
`timescale 1ns/100ps
`default_nettype none

module block_sync_top
        import pcs_rx_pkg::*;
(
        input  logic                            i_clock,
        input  logic                            i_arst_n,
        input  logic [NB_DATA_BUS-1:0]          i_data,
        input  logic                            i_valid,
        input  logic                            i_enable,
        input  logic                            i_signal_ok,
        input  logic [NB_WINDOW_CNT-1:0]        i_rf_unlocked_timer_limit,
        input  logic [NB_WINDOW_CNT-1:0]        i_rf_locked_timer_limit,
        input  logic [NB_INVALID_CNT-1:0]       i_rf_sh_invalid_limit,
        output logic [NB_DATA_BUS-1:0]          o_data,
        output logic                            o_valid,
        output logic [N_LANES-1:0]              o_sh_bus,
        output logic [N_LANES-1:0]              o_block_lock
);

        logic [NB_DATA_BUS-1:0] data_q;
        logic [N_LANES-1:0]     valid_q;
        logic [N_LANES-1:0]     enable_q;

        logic [NB_DATA_BUS-1:0] lane_data;
        logic [N_LANES-1:0]     lane_valid;
        logic [N_LANES-1:0]     lane_sh;

        // ******************************************************************
        // input stage, one valid and enable copy per lane
        // ******************************************************************

        always_ff @(posedge i_clock or negedge i_arst_n) begin
                if (!i_arst_n) begin
                        data_q <= '0;
                        valid_q <= '0;
                        enable_q <= '0;
                end
                else begin
                        data_q <= i_data;
                        valid_q <= {N_LANES{i_valid}};
                        enable_q <= {N_LANES{i_enable}};
                end
        end

        for (genvar i = 0; i < N_LANES; i++) begin : g_lane
                block_sync_lane u_lane (
                        .i_clock                (i_clock),
                        .i_arst_n               (i_arst_n),
                        .i_valid                (valid_q[i]),
                        .i_enable               (enable_q[i]),
                        .i_signal_ok            (i_signal_ok),
                        .i_data                 (data_q[i*NB_BLOCK +: NB_BLOCK]),
                        .i_unlocked_timer_limit (i_rf_unlocked_timer_limit),
                        .i_locked_timer_limit   (i_rf_locked_timer_limit),
                        .i_sh_invalid_limit     (i_rf_sh_invalid_limit),
                        .o_data                 (lane_data[i*NB_BLOCK +: NB_BLOCK]),
                        .o_valid                (lane_valid[i]),
                        .o_sh_valid             (lane_sh[i]),
                        .o_block_lock           (o_block_lock[i])
                );
        end

        // ******************************************************************
        // output stage
        // ******************************************************************

        // all lanes see the same valid, lane 0 speaks for them.
        always_ff @(posedge i_clock or negedge i_arst_n) begin
                if (!i_arst_n) begin
                        o_data <= '0;
                        o_valid <= 1'b0;
                        o_sh_bus <= '0;
                end
                else begin
                        o_data <= lane_data;
                        o_valid <= lane_valid[0];
                        o_sh_bus <= lane_sh;
                end
        end

endmodule

`default_nettype wire

// File: sim/tb_block_sync_top.sv
`timescale 1ns/100ps
`default_nettype none

module tb_block_sync_top
        import pcs_rx_pkg::*;
();

        localparam int UNLOCK_LIMIT = 16;
        localparam int WINDOW_LIMIT = 64;
        localparam int INVALID_LIMIT = 8;
        // worst case 66 slips per lock at 16 blocks each plus the good run.
        localparam int LOCK_BUDGET = 66 * 16 + UNLOCK_LIMIT;
        localparam int TEST_BLOCKS = 600;
        localparam int WATCHDOG_NS = (4 * LOCK_BUDGET + TEST_BLOCKS) * 2 * 10;

        logic                           i_clock = 1'b0;
        logic                           i_arst_n;
        logic [NB_DATA_BUS-1:0]         i_data;
        logic                           i_valid;
        logic                           i_enable;
        logic                           i_signal_ok;
        logic [NB_WINDOW_CNT-1:0]       i_rf_unlocked_timer_limit;
        logic [NB_WINDOW_CNT-1:0]       i_rf_locked_timer_limit;
        logic [NB_INVALID_CNT-1:0]      i_rf_sh_invalid_limit;
        logic [NB_DATA_BUS-1:0]         o_data;
        logic                           o_valid;
        logic [N_LANES-1:0]             o_sh_bus;
        logic [N_LANES-1:0]             o_block_lock;

        logic [31:0]                    rng = 32'h6a86_3265;
        int                             offset [N_LANES] = '{5, 23, 41, 60};
        logic [NB_BLOCK-1:0]            prev_blk [N_LANES];
        logic                           prev_bad [N_LANES];
        // one entry per valid word with bad flags above the lane blocks.
        logic [NB_DATA_BUS+N_LANES-1:0] exp_q [$];
        logic [NB_DATA_BUS+N_LANES-1:0] entry;
        logic                           check_en = 1'b0;
        int                             errors = 0;
        int                             checks = 0;
        int                             tests = 0;
        int                             out_count = 0;

        block_sync_top uut (.*);

        always #5 i_clock = ~i_clock;

        function logic [31:0] xorshift(input logic [31:0] s);
                logic [31:0] x;
                x = s ^ (s << 13);
                x = x ^ (x >> 17);
                return x ^ (x << 5);
        endfunction

        // a bad block gets header 00 or 11.
        function logic [NB_BLOCK-1:0] make_block(input logic bad);
                logic [63:0] payload;
                rng = xorshift(rng);
                payload[63:32] = rng;
                rng = xorshift(rng);
                payload[31:0] = rng;
                rng = xorshift(rng);
                if (bad) begin
                        return {{NB_SH{rng[0]}}, payload};
                end
                return {rng[0] ? SH_CTRL : SH_DATA, payload};
        endfunction

        task automatic check_block(input string name, input logic [NB_BLOCK-1:0] got,
                                   input logic [NB_BLOCK-1:0] exp);
                checks++;
                if (got !== exp) begin
                        $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
                        errors++;
                end
        endtask

        task automatic check_lock(input logic [N_LANES-1:0] exp);
                checks++;
                if (o_block_lock !== exp) begin
                        $display("[FAIL] %0t o_block_lock got %b expected %b",
                                 $time, o_block_lock, exp);
                        errors++;
                end
        endtask

        task automatic check_bit(input string name, input logic got, input logic exp);
                checks++;
                if (got !== exp) begin
                        $display("[FAIL] %0t %s got %b expected %b", $time, name, got, exp);
                        errors++;
                end
        endtask

        // *********************************************************************
        // lane stream model
        // *********************************************************************

        // each lane word holds the stream shifted late by its offset.
        task automatic send_word(input logic [N_LANES-1:0] bad, input logic valid);
                logic [NB_BLOCK-1:0]            blk;
                logic [2*NB_BLOCK-1:0]          cat;
                logic [NB_DATA_BUS-1:0]         bus;
                logic [NB_DATA_BUS+N_LANES-1:0] e;
                @(posedge i_clock);
                bus = '0;
                e = '0;
                if (valid) begin
                        for (int l = 0; l < N_LANES; l++) begin
                                blk = make_block(bad[l]);
                                cat = {prev_blk[l], blk};
                                bus[l*NB_BLOCK +: NB_BLOCK] = cat[NB_BLOCK-1+offset[l] -: NB_BLOCK];
                                e[l*NB_BLOCK +: NB_BLOCK] = prev_blk[l];
                                e[NB_DATA_BUS+l] = prev_bad[l];
                                prev_blk[l] = blk;
                                prev_bad[l] = bad[l];
                        end
                        exp_q.push_back(e);
                end
                i_data <= bus;
                i_valid <= valid;
                @(negedge i_clock);
        endtask

        task automatic idle(input int n);
                repeat (n) send_word('0, 1'b0);
        endtask

        task automatic wait_lock(input logic [N_LANES-1:0] mask);
                int n;
                n = 0;
                while ((o_block_lock & mask) != mask && n < LOCK_BUDGET) begin
                        send_word('0, 1'b1);
                        n++;
                end
                if ((o_block_lock & mask) != mask) begin
                        $display("lanes %b did not lock within %0d blocks", mask, LOCK_BUDGET);
                        errors++;
                end
        endtask

        task automatic report(input string name, input int err0);
                tests++;
                $display("test %s: %s", name, (errors == err0) ? "ok" : "errors");
        endtask

        // outputs compared only on lanes that are locked.
        always @(negedge i_clock) begin
                if (i_arst_n && o_valid) begin
                        out_count++;
                        if (exp_q.size() == 0) begin
                                $display("output block at %0t with nothing expected", $time);
                                errors++;
                        end
                        else begin
                                entry = exp_q.pop_front();
                                for (int l = 0; l < N_LANES; l++) begin
                                        if (check_en && o_block_lock[l]) begin
                                                check_block($sformatf("o_data[lane %0d]", l),
                                                            o_data[l*NB_BLOCK +: NB_BLOCK],
                                                            entry[l*NB_BLOCK +: NB_BLOCK]);
                                                check_bit($sformatf("o_sh_bus[%0d]", l),
                                                          o_sh_bus[l], !entry[NB_DATA_BUS+l]);
                                        end
                                end
                        end
                end
        end

        // *********************************************************************
        // directed tests
        // *********************************************************************

        task automatic test_reset();
                int e0;
                e0 = errors;
                check_bit("o_valid", o_valid, 1'b0);
                for (int l = 0; l < N_LANES; l++) begin
                        check_bit($sformatf("o_sh_bus[%0d]", l), o_sh_bus[l], 1'b0);
                end
                check_lock('0);
                report("reset", e0);
        endtask

        task automatic test_lock();
                int e0;
                e0 = errors;
                check_en = 1'b1;
                wait_lock('1);
                repeat (WINDOW_LIMIT) send_word('0, 1'b1);
                idle(4);
                check_lock('1);
                report("lock acquisition", e0);
        endtask

        task automatic test_tolerated();
                int e0;
                e0 = errors;
                repeat (10) send_word('0, 1'b1);
                for (int i = 0; i < INVALID_LIMIT - 1; i++) begin
                        send_word({2'b00, 1'b1, i < 3}, 1'b1);
                end
                repeat (20) send_word('0, 1'b1);
                idle(4);
                check_lock('1);
                report("tolerated errors", e0);
        endtask

        task automatic test_loss();
                int e0;
                e0 = errors;
                // twice the limit so one window always holds enough.
                repeat (2 * INVALID_LIMIT) send_word(4'b0100, 1'b1);
                idle(4);
                check_lock(4'b1011);
                wait_lock('1);
                repeat (40) send_word('0, 1'b1);
                idle(4);
                check_lock('1);
                report("loss of lock", e0);
        endtask

        task automatic test_signal_enable();
                int e0;
                e0 = errors;
                @(posedge i_clock);
                i_signal_ok <= 1'b0;
                repeat (2) send_word('0, 1'b1);
                check_lock('0);
                // end the last word so it is not sampled twice.
                @(posedge i_clock);
                i_valid <= 1'b0;
                i_signal_ok <= 1'b1;
                wait_lock('1);
                @(posedge i_clock);
                i_valid <= 1'b0;
                i_enable <= 1'b0;
                repeat (2 * INVALID_LIMIT) send_word('1, 1'b1);
                idle(4);
                check_lock('1);
                @(posedge i_clock);
                i_enable <= 1'b1;
                repeat (20) send_word('0, 1'b1);
                idle(4);
                check_lock('1);
                report("signal loss and enable", e0);
        endtask

        task automatic test_gaps();
                int e0;
                int out0;
                int sent;
                e0 = errors;
                idle(4);
                out0 = out_count;
                sent = 0;
                // o_valid trails the driven valid by three words.
                for (int i = 0; i < 60; i++) begin
                        send_word('0, (i % 3) != 0);
                        sent += ((i % 3) != 0);
                        check_bit("o_valid", o_valid, (i >= 3) && (((i - 3) % 3) != 0));
                end
                idle(4);
                if (out_count - out0 != sent) begin
                        $display("%0d blocks sent but %0d came out", sent, out_count - out0);
                        errors++;
                end
                if (exp_q.size() != 0) begin
                        $display("%0d expected blocks never came out", exp_q.size());
                        errors++;
                end
                check_lock('1);
                report("valid gaps", e0);
        endtask

        initial begin
                i_arst_n = 1'b0;
                i_data = '0;
                i_valid = 1'b0;
                i_enable = 1'b1;
                i_signal_ok = 1'b1;
                i_rf_unlocked_timer_limit = NB_WINDOW_CNT'(UNLOCK_LIMIT);
                i_rf_locked_timer_limit = NB_WINDOW_CNT'(WINDOW_LIMIT);
                i_rf_sh_invalid_limit = NB_INVALID_CNT'(INVALID_LIMIT);
                for (int l = 0; l < N_LANES; l++) begin
                        prev_blk[l] = make_block(1'b0);
                        prev_bad[l] = 1'b0;
                end
                repeat (4) @(posedge i_clock);
                i_arst_n <= 1'b1;
                @(negedge i_clock);
                test_reset();
                test_lock();
                test_tolerated();
                test_loss();
                test_signal_enable();
                test_gaps();
                $display("tests: %0d  checks: %0d  errors: %0d", tests, checks, errors);
                if (errors == 0) begin
                        $display("PASS: all tests");
                end
                else begin
                        $display("FAIL: see errors above");
                end
                $finish;
        end

        initial begin
                #(WATCHDOG_NS);
                $display("watchdog expired after %0d ns, run did not finish", WATCHDOG_NS);
                $display("FAIL: see errors above");
                $finish;
        end

endmodule

`default_nettype wire

// File: block_sync_top.f
logic/pcs_rx_pkg.sv
logic/block_aligner.sv
logic/block_lock_fsm.sv
logic/block_sync_lane.sv
logic/block_sync_top.sv
sim/tb_block_sync_top.sv

// File: Bender.yml
package:
  name: block_sync_top

sources:
  - files:
      - logic/pcs_rx_pkg.sv
      - logic/block_aligner.sv
      - logic/block_lock_fsm.sv
      - logic/block_sync_lane.sv
      - logic/block_sync_top.sv
  - target: simulation
    files:
      - sim/tb_block_sync_top.sv
